//--- Bender.yml
package:
  name: ex_unit

sources:
  - target: rtl
    files:
      - logic/ex_pkg.sv
      - logic/muldiv_if.sv
      - logic/alu.sv
      - logic/multiplier.sv
      - logic/divider.sv
      - logic/hilo_reg.sv
      - logic/ex_unit.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/ex_unit_tb.sv

//--- list.f
logic/ex_pkg.sv
logic/muldiv_if.sv
logic/alu.sv
logic/multiplier.sv
logic/divider.sv
logic/hilo_reg.sv
logic/ex_unit.sv
tb/tb_clock.sv
tb/ex_unit_tb.sv

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic             clk,
    input  logic             reset,
    input  logic             op_valid,
    input  ex_pkg::alu_op_e  alu_sel,
    input  ex_pkg::word_t    src_a,
    input  ex_pkg::word_t    src_b,
    input  ex_pkg::word_t    hi_q,
    input  ex_pkg::word_t    lo_q,
    output ex_pkg::word_t    alu_res,
    output logic             res_valid,
    output logic             stall_req,
    output logic             hi_we,
    output logic             lo_we,
    output ex_pkg::word_t    hi_wdata,
    output ex_pkg::word_t    lo_wdata,
    muldiv_if.master         mul_bus,
    muldiv_if.master         div_bus
);
    import ex_pkg::*;

    logic  is_mul;
    logic  is_div;
    logic  start_any;
    logic  done_any;
    logic  pending_q;
    logic  busy_wait;
    logic  mt_hi;
    logic  mt_lo;
    word_t done_hi;
    word_t done_lo;

    assign is_mul = (alu_sel == MULT) || (alu_sel == MULTU);
    assign is_div = (alu_sel == DIV) || (alu_sel == DIVU);

    // Operands go to both units; only the strobed one latches them.
    assign mul_bus.start     = op_valid && is_mul;
    assign mul_bus.is_signed = (alu_sel == MULT);
    assign mul_bus.a         = src_a;
    assign mul_bus.b         = src_b;

    assign div_bus.start     = op_valid && is_div;
    assign div_bus.is_signed = (alu_sel == DIV);
    assign div_bus.a         = src_a;
    assign div_bus.b         = src_b;

    assign start_any = mul_bus.start || div_bus.start;
    assign done_any  = mul_bus.done || div_bus.done;

    // One long operation in flight at most.
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= 1'b0;
        end else if (start_any) begin
            pending_q <= 1'b1;
        end else if (done_any) begin
            pending_q <= 1'b0;
        end
    end

    assign busy_wait = pending_q && !done_any;
    assign stall_req = start_any || busy_wait;
    assign res_valid = op_valid && !is_mul && !is_div;

    // HI/LO write port; a move issued in the done cycle wins over the unit result.
    assign mt_hi   = op_valid && (alu_sel == MTHI);
    assign mt_lo   = op_valid && (alu_sel == MTLO);
    assign done_hi = mul_bus.done ? mul_bus.hi : div_bus.hi;
    assign done_lo = mul_bus.done ? mul_bus.lo : div_bus.lo;

    assign hi_we    = mt_hi || done_any;
    assign lo_we    = mt_lo || done_any;
    assign hi_wdata = mt_hi ? src_a : done_hi;
    assign lo_wdata = mt_lo ? src_a : done_lo;

    always_comb begin
        case (alu_sel)
            ADD:     alu_res = src_a + src_b;
            SUB:     alu_res = src_a - src_b;
            SLT:     alu_res = {31'd0, $signed(src_a) < $signed(src_b)};
            SLTU:    alu_res = {31'd0, src_a < src_b};
            AND:     alu_res = src_a & src_b;
            OR:      alu_res = src_a | src_b;
            XOR:     alu_res = src_a ^ src_b;
            NOR:     alu_res = ~(src_a | src_b);
            SLL:     alu_res = src_a << src_b[4:0];
            SRL:     alu_res = src_a >> src_b[4:0];
            SRA:     alu_res = $signed(src_a) >>> src_b[4:0];
            LUI:     alu_res = {src_b[15:0], 16'h0000};
            MFHI:    alu_res = hi_q;
            MFLO:    alu_res = lo_q;
            default: alu_res = '0;
        endcase
    end

    // The issuer must hold off while a multiply or divide is still running.
    assert property (@(posedge clk) disable iff (reset) op_valid |-> !busy_wait)
        else $error("op_valid issued while stall_req is high");

    assert property (@(posedge clk) disable iff (reset) !(mul_bus.busy && div_bus.busy))
        else $error("multiplier and divider busy at the same time");

endmodule

//--- logic/divider.sv
`timescale 1ns/1ps

module divider (
    input  logic   clk,
    input  logic   reset,
    muldiv_if.unit bus
);
    import ex_pkg::*;

    localparam logic [5:0] FIX_STEP = 6'd32;

    div_state_e  state_q;
    logic [5:0]  step_q;
    word_t       quo_q;
    word_t       rem_q;
    word_t       dvs_q;
    logic        q_neg_q;
    logic        r_neg_q;

    word_t       mag_a;
    word_t       mag_b;
    logic [32:0] shifted;
    logic [32:0] diff;
    logic        take;

    assign mag_a = (bus.is_signed && bus.a[31]) ? -bus.a : bus.a;
    assign mag_b = (bus.is_signed && bus.b[31]) ? -bus.b : bus.b;

    // Partial remainder with the next dividend bit shifted in.
    assign shifted = {rem_q, quo_q[31]};
    assign diff    = shifted - {1'b0, dvs_q};
    assign take    = shifted >= {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            step_q  <= '0;
        end else if (bus.start) begin
            state_q <= RUN;
            step_q  <= '0;
        end else begin
            case (state_q)
                RUN: begin
                    if (step_q == FIX_STEP) begin
                        state_q <= DONE;
                    end
                    step_q <= step_q + 6'd1;
                end
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            quo_q   <= mag_a;
            rem_q   <= '0;
            dvs_q   <= mag_b;
            // Zero divisor keeps the all-ones quotient unsigned.
            q_neg_q <= bus.is_signed && (bus.a[31] ^ bus.b[31]) && (bus.b != '0);
            r_neg_q <= bus.is_signed && bus.a[31];
        end else if (state_q == RUN) begin
            if (step_q == FIX_STEP) begin
                quo_q <= q_neg_q ? -quo_q : quo_q;
                rem_q <= r_neg_q ? -rem_q : rem_q;
            end else begin
                rem_q <= take ? diff[31:0] : shifted[31:0];
                quo_q <= {quo_q[30:0], take};
            end
        end
    end

    assign bus.busy = (state_q == RUN);
    assign bus.done = (state_q == DONE);
    assign bus.hi   = rem_q;
    assign bus.lo   = quo_q;

    assert property (@(posedge clk) disable iff (reset) bus.done |=> !bus.done)
        else $error("divider done held longer than one cycle");

    assert property (@(posedge clk) disable iff (reset) bus.start |-> !bus.busy)
        else $error("divider started while busy");

endmodule

//--- logic/ex_pkg.sv
package ex_pkg;

    // Data word of the integer datapath.
    typedef logic [31:0] word_t;

    // Execute-stage operation select.
    typedef enum logic [5:0] {
        NOP,
        ADD,
        SUB,
        SLT,
        SLTU,
        AND,
        OR,
        XOR,
        NOR,
        SLL,
        SRL,
        SRA,
        LUI,
        MULT,
        MULTU,
        DIV,
        DIVU,
        MTHI,
        MTLO,
        MFHI,
        MFLO
    } alu_op_e;

    // Divider control states.
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_e;

    // Multiplier cycles from the start strobe to the HI/LO write.
    localparam int MUL_LATENCY_DEF = 4;

endpackage

//--- logic/ex_unit.sv
`timescale 1ns/1ps

module ex_unit #(
    parameter int MUL_LATENCY = ex_pkg::MUL_LATENCY_DEF
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            op_valid,
    input  ex_pkg::alu_op_e alu_sel,
    input  ex_pkg::word_t   src_a,
    input  ex_pkg::word_t   src_b,
    output ex_pkg::word_t   alu_res,
    output logic            res_valid,
    output logic            stall_req,
    output ex_pkg::word_t   hi,
    output ex_pkg::word_t   lo
);
    import ex_pkg::*;

    logic  hi_we;
    logic  lo_we;
    word_t hi_wdata;
    word_t lo_wdata;
    word_t hi_q;
    word_t lo_q;

    muldiv_if mul_bus ();
    muldiv_if div_bus ();

    alu alu_i (
        .clk       (clk),
        .reset     (reset),
        .op_valid  (op_valid),
        .alu_sel   (alu_sel),
        .src_a     (src_a),
        .src_b     (src_b),
        .hi_q      (hi_q),
        .lo_q      (lo_q),
        .alu_res   (alu_res),
        .res_valid (res_valid),
        .stall_req (stall_req),
        .hi_we     (hi_we),
        .lo_we     (lo_we),
        .hi_wdata  (hi_wdata),
        .lo_wdata  (lo_wdata),
        .mul_bus   (mul_bus.master),
        .div_bus   (div_bus.master)
    );

    multiplier #(
        .LATENCY (MUL_LATENCY)
    ) mul_i (
        .clk   (clk),
        .reset (reset),
        .bus   (mul_bus.unit)
    );

    divider div_i (
        .clk   (clk),
        .reset (reset),
        .bus   (div_bus.unit)
    );

    hilo_reg hilo_i (
        .clk      (clk),
        .reset    (reset),
        .hi_we    (hi_we),
        .lo_we    (lo_we),
        .hi_wdata (hi_wdata),
        .lo_wdata (lo_wdata),
        .hi_q     (hi_q),
        .lo_q     (lo_q),
        .hi_r     (hi),
        .lo_r     (lo)
    );

endmodule

//--- logic/hilo_reg.sv
`timescale 1ns/1ps

module hilo_reg (
    input  logic          clk,
    input  logic          reset,
    input  logic          hi_we,
    input  logic          lo_we,
    input  ex_pkg::word_t hi_wdata,
    input  ex_pkg::word_t lo_wdata,
    output ex_pkg::word_t hi_q,
    output ex_pkg::word_t lo_q,
    output ex_pkg::word_t hi_r,
    output ex_pkg::word_t lo_r
);

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_r <= '0;
            lo_r <= '0;
        end else begin
            if (hi_we) begin
                hi_r <= hi_wdata;
            end
            if (lo_we) begin
                lo_r <= lo_wdata;
            end
        end
    end

    // Same-cycle forwarding, so a read right after a write sees the new value.
    assign hi_q = hi_we ? hi_wdata : hi_r;
    assign lo_q = lo_we ? lo_wdata : lo_r;

endmodule

//--- logic/muldiv_if.sv
`timescale 1ns/1ps

interface muldiv_if;
    import ex_pkg::*;

    // Request side, driven by the ALU.
    logic  start;
    logic  is_signed;
    word_t a;
    word_t b;

    // Completion side, driven by the unit.
    logic  busy;
    logic  done;
    word_t hi;
    word_t lo;

    modport master (
        output start, is_signed, a, b,
        input  busy, done, hi, lo
    );

    modport unit (
        input  start, is_signed, a, b,
        output busy, done, hi, lo
    );

endinterface

//--- logic/multiplier.sv
`timescale 1ns/1ps

module multiplier #(
    parameter int LATENCY = ex_pkg::MUL_LATENCY_DEF
) (
    input  logic   clk,
    input  logic   reset,
    muldiv_if.unit bus
);
    import ex_pkg::*;

    // Stage 0 holds the operands, stages 1 to LATENCY-1 hold the product.
    logic [LATENCY-1:0] vld_q;
    word_t              op_a_q;
    word_t              op_b_q;
    logic               neg_q;
    logic [63:0]        prod_q [1:LATENCY-1];

    word_t       mag_a;
    word_t       mag_b;
    logic [63:0] mag_prod;

    assign mag_a = (bus.is_signed && bus.a[31]) ? -bus.a : bus.a;
    assign mag_b = (bus.is_signed && bus.b[31]) ? -bus.b : bus.b;

    assign mag_prod = op_a_q * op_b_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[LATENCY-2:0], bus.start};
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            op_a_q <= mag_a;
            op_b_q <= mag_b;
            neg_q  <= bus.is_signed && (bus.a[31] ^ bus.b[31]);
        end
        prod_q[1] <= neg_q ? -mag_prod : mag_prod;
        for (int i = 2; i < LATENCY; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

    // Busy covers the cycles before the result; it drops as done rises.
    assign bus.busy = |vld_q[LATENCY-2:0];
    assign bus.done = vld_q[LATENCY-1];
    assign bus.hi   = prod_q[LATENCY-1][63:32];
    assign bus.lo   = prod_q[LATENCY-1][31:0];

    assert property (@(posedge clk) disable iff (reset) bus.start |-> !bus.busy)
        else $error("multiplier started while busy");

endmodule

//--- tb/ex_unit_tb.sv
`timescale 1ns/1ps

module ex_unit_tb;
    import ex_pkg::*;

    localparam int          MUL_LATENCY     = MUL_LATENCY_DEF;
    localparam int unsigned SEED            = 32'hb029790e;
    localparam int          NUM_TESTS       = 34;
    localparam int          WATCHDOG_CYCLES = NUM_TESTS * 40 + 200;
    localparam int          STALL_LIMIT     = 50;

    logic    clk;
    logic    reset;
    logic    op_valid;
    alu_op_e alu_sel;
    word_t   src_a;
    word_t   src_b;
    word_t   alu_res;
    logic    res_valid;
    logic    stall_req;
    word_t   hi;
    word_t   lo;

    string       cur_test;
    int          err_count;
    int          err_mark;
    int          tests_run;
    int          tests_failed;
    int unsigned seed_val;
    word_t       model_hi;
    word_t       model_lo;
    word_t       corner_vals[3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
    alu_op_e     single_ops[12] = '{ADD, SUB, SLT, SLTU, AND, OR, XOR, NOR, SLL, SRL, SRA, LUI};

    tb_clock #(.PERIOD(4ns), .RESET_CYCLES(3)) clock_i (.clk(clk), .reset(reset));

    ex_unit #(.MUL_LATENCY(MUL_LATENCY)) dut_i (
        .clk       (clk),
        .reset     (reset),
        .op_valid  (op_valid),
        .alu_sel   (alu_sel),
        .src_a     (src_a),
        .src_b     (src_b),
        .alu_res   (alu_res),
        .res_valid (res_valid),
        .stall_req (stall_req),
        .hi        (hi),
        .lo        (lo)
    );

    // Reference model.
    function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
        word_t r;
        int    sh;
        sh = b[4:0];
        case (op)
            ADD:     r = a + b;
            SUB:     r = a - b;
            SLT:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    r = (a < b) ? 32'd1 : 32'd0;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            NOR:     r = ~(a | b);
            SLL:     r = a << sh;
            SRL:     r = a >> sh;
            SRA: begin
                r = a;
                for (int i = 0; i < sh; i++) begin
                    r = {r[31], r[31:1]};
                end
            end
            LUI:     r = b << 16;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [63:0] mul_model(bit sgn, word_t a, word_t b);
        longint      p;
        logic [63:0] ua;
        logic [63:0] ub;
        ua = {32'd0, a};
        ub = {32'd0, b};
        p  = longint'($signed(a)) * longint'($signed(b));
        return sgn ? p : ua * ub;
    endfunction

    // Returns {remainder, quotient}.
    function automatic logic [63:0] div_model(bit sgn, word_t a, word_t b);
        longint sa;
        longint sb;
        longint q;
        longint r;
        if (b == '0) begin
            return {a, 32'hffff_ffff};
        end
        sa = sgn ? longint'($signed(a)) : longint'({32'd0, a});
        sb = sgn ? longint'($signed(b)) : longint'({32'd0, b});
        q  = sa / sb;
        r  = sa % sb;
        return {r[31:0], q[31:0]};
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            err_count++;
            $display("ERR %s %s: expected %08h, actual %08h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            err_count++;
            $display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_hilo(input word_t exp_hi, input word_t exp_lo);
        if (hi !== exp_hi || lo !== exp_lo) begin
            err_count++;
            $display("ERR %s hi:lo: expected %08h:%08h, actual %08h:%08h",
                     cur_test, exp_hi, exp_lo, hi, lo);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = err_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_count != err_mark) begin
            tests_failed++;
            $display("%-12s failed", cur_test);
        end else begin
            $display("%-12s ok", cur_test);
        end
    endtask

    task automatic drive_op(input alu_op_e op, input word_t a, input word_t b);
        @(posedge clk);
        op_valid <= 1'b1;
        alu_sel  <= op;
        src_a    <= a;
        src_b    <= b;
    endtask

    task automatic idle();
        @(posedge clk);
        op_valid <= 1'b0;
        alu_sel  <= NOP;
        src_a    <= '0;
        src_b    <= '0;
    endtask

    task automatic issue_alu(input alu_op_e op, input word_t a, input word_t b);
        drive_op(op, a, b);
        @(negedge clk);
        check_flag("res_valid", 1'b1, res_valid);
        check_flag("stall_req", 1'b0, stall_req);
        check_word("alu_res", alu_model(op, a, b), alu_res);
    endtask

    // Counts the cycles that stall_req is still high, sampled on falling edges.
    task automatic wait_release(output int cycles, output bit released);
        cycles   = 0;
        released = 1'b0;
        while (!released && cycles < STALL_LIMIT) begin
            @(negedge clk);
            if (stall_req) begin
                cycles++;
            end else begin
                released = 1'b1;
            end
        end
    endtask

    task automatic test_reset();
        begin_test("reset_state");
        @(negedge clk);
        check_hilo('0, '0);
        check_flag("res_valid", 1'b0, res_valid);
        check_flag("stall_req", 1'b0, stall_req);
        model_hi = '0;
        model_lo = '0;
        end_test();
    endtask

    task automatic run_alu_test(input alu_op_e op);
        word_t a;
        word_t b;
        begin_test(op.name());
        foreach (corner_vals[i]) begin
            foreach (corner_vals[j]) begin
                issue_alu(op, corner_vals[i], corner_vals[j]);
            end
        end
        repeat (8) begin
            a = $urandom();
            b = $urandom();
            issue_alu(op, a, b);
        end
        idle();
        end_test();
    endtask

    task automatic run_long(input string name, input alu_op_e op, input word_t a, input word_t b);
        logic [63:0] exp;
        bit          is_mul;
        int          cycles;
        bit          released;
        begin_test(name);
        is_mul = (op == MULT) || (op == MULTU);
        exp = is_mul ? mul_model(op == MULT, a, b) : div_model(op == DIV, a, b);
        drive_op(op, a, b);
        @(negedge clk);
        check_flag("stall_req", 1'b1, stall_req);
        check_flag("res_valid", 1'b0, res_valid);
        idle();
        wait_release(cycles, released);
        if (!released) begin
            err_count++;
            $display("%s: stall_req still high after %0d cycles", cur_test, STALL_LIMIT);
        end else begin
            if (is_mul) begin
                check_word("latency", word_t'(MUL_LATENCY), word_t'(cycles + 1));
            end
            // HI/LO take the result on the edge that ends the done cycle.
            @(posedge clk);
            @(negedge clk);
            check_hilo(exp[63:32], exp[31:0]);
        end
        model_hi = exp[63:32];
        model_lo = exp[31:0];
        end_test();
    endtask

    task automatic test_moves();
        word_t h1;
        word_t l1;
        begin_test("mt_mf");
        h1 = $urandom();
        l1 = $urandom();
        drive_op(MTHI, h1, $urandom());
        drive_op(MFHI, $urandom(), $urandom());
        @(negedge clk);
        check_word("mfhi after mthi", h1, alu_res);
        check_flag("res_valid", 1'b1, res_valid);
        check_hilo(h1, model_lo);
        drive_op(MTLO, l1, '0);
        drive_op(MFLO, '0, '0);
        @(negedge clk);
        check_word("mflo after mtlo", l1, alu_res);
        check_hilo(h1, l1);
        drive_op(MFHI, '0, '0);
        @(negedge clk);
        check_word("mfhi", h1, alu_res);
        idle();
        model_hi = h1;
        model_lo = l1;
        end_test();
    endtask

    task automatic test_nop();
        begin_test("nop");
        repeat (4) begin
            drive_op(NOP, $urandom(), $urandom());
        end
        idle();
        @(negedge clk);
        check_hilo(model_hi, model_lo);
        end_test();
    endtask

    initial begin
        op_valid     = 1'b0;
        alu_sel      = NOP;
        src_a        = '0;
        src_b        = '0;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed_val     = $urandom(SEED);
        wait (reset === 1'b0);
        test_reset();
        foreach (single_ops[i]) begin
            run_alu_test(single_ops[i]);
        end
        run_long("mult_small", MULT, 32'd3, 32'd5);
        run_long("mult_neg", MULT, -32'sd3, 32'd5);
        run_long("mult_min", MULT, 32'h8000_0000, 32'h8000_0000);
        run_long("mult_m1", MULT, 32'hffff_ffff, 32'hffff_ffff);
        run_long("mult_rand", MULT, $urandom(), $urandom());
        run_long("multu_ones", MULTU, 32'hffff_ffff, 32'hffff_ffff);
        run_long("multu_rand", MULTU, $urandom(), $urandom());
        run_long("multu_top", MULTU, 32'h8000_0000, 32'd2);
        run_long("div_pp", DIV, 32'd100, 32'd7);
        run_long("div_np", DIV, -32'sd100, 32'd7);
        run_long("div_pn", DIV, 32'd100, -32'sd7);
        run_long("div_nn", DIV, -32'sd100, -32'sd7);
        run_long("div_min_m1", DIV, 32'h8000_0000, 32'hffff_ffff);
        run_long("div_rand", DIV, $urandom(), $urandom() >> 8);
        run_long("divu_ones", DIVU, 32'hffff_ffff, 32'd3);
        run_long("divu_rand", DIVU, $urandom(), $urandom() >> 12);
        run_long("divu_big", DIVU, 32'd7, 32'h8000_0000);
        run_long("div_zero", DIV, -32'sd5, 32'd0);
        run_long("divu_zero", DIVU, 32'h1234_abcd, 32'd0);
        test_moves();
        test_nop();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter realtime PERIOD       = 4ns,
    parameter int      RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset is released on a rising edge, so the DUT sees it for RESET_CYCLES edges.
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule
